// File: source/rv_pkg.sv
package rv_pkg;

	// Data and address width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// Major opcodes kept by this core
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	// ALU operations including shifts
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	// Classes the FSM steers on after execute
	typedef enum logic [2:0] {
		cls_alu, cls_branch, cls_jump, cls_load, cls_store, cls_upper, cls_other
	} op_class_e;

	// Field layouts of the instruction word with MSB first
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One word seen in six layouts
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	// Decoded instruction of 62 bits
	typedef struct packed {
		op_class_e  op_class;
		reg_addr_t  rd;
		reg_addr_t  rs1;
		reg_addr_t  rs2;
		logic [2:0] funct3;
		word_t      imm;
		alu_op_e    alu_op;
		// PC instead of rs1 as operand A
		logic       src_a_pc;
		// Immediate instead of rs2 as operand B
		logic       src_b_imm;
		logic       is_jalr;
		logic       is_lui;
		// Write back PC plus 4
		logic       link;
	} decode_t;

endpackage

// File: source/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	input  rv_pkg::alu_op_e op,
	output rv_pkg::word_t   result,
	output logic            zero
);

	logic [4:0] shamt;

	// Only low five bits shift
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			rv_pkg::alu_add: begin
				result = a + b;
			end
			rv_pkg::alu_sub: begin
				result = a - b;
			end
			rv_pkg::alu_and: begin
				result = a & b;
			end
			rv_pkg::alu_or: begin
				result = a | b;
			end
			rv_pkg::alu_xor: begin
				result = a ^ b;
			end
			// Compare result lands in bit 0
			rv_pkg::alu_slt: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			rv_pkg::alu_sltu: begin
				result = {31'b0, a < b};
			end
			rv_pkg::alu_sll: begin
				result = a << shamt;
			end
			rv_pkg::alu_srl: begin
				result = a >> shamt;
			end
			rv_pkg::alu_sra: begin
				result = $signed(a) >>> shamt;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// Equality for BEQ and BNE
	assign zero = (result == '0);

endmodule

// File: source/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
	input  rv_pkg::word_t   instr_word,
	output rv_pkg::decode_t dec
);

	rv_pkg::instr_u w;

	// Map funct3 to ALU op, alt picks sub or sra
	function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		rv_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001:  op = rv_pkg::alu_sll;
			3'b010:  op = rv_pkg::alu_slt;
			3'b011:  op = rv_pkg::alu_sltu;
			3'b100:  op = rv_pkg::alu_xor;
			3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110:  op = rv_pkg::alu_or;
			default: op = rv_pkg::alu_and;
		endcase
		return op;
	endfunction

	assign w = instr_word;

	always_comb begin
		// Register fields sit at the same place in every layout
		dec           = '0;
		dec.op_class  = rv_pkg::cls_other;
		dec.alu_op    = rv_pkg::alu_add;
		dec.rd        = w.r.rd;
		dec.rs1       = w.r.rs1;
		dec.rs2       = w.r.rs2;
		dec.funct3    = w.r.funct3;
		case (w.r.opcode)
			rv_pkg::opc_op: begin
				dec.op_class = rv_pkg::cls_alu;
				dec.alu_op   = alu_sel(w.r.funct3, w.r.funct7[5]);
			end
			rv_pkg::opc_op_imm: begin
				dec.op_class  = rv_pkg::cls_alu;
				dec.src_b_imm = 1'b1;
				// Bit 30 only matters for srai here
				dec.alu_op    = alu_sel(w.i.funct3, w.r.funct7[5] & (w.i.funct3 == 3'b101));
				// SLTIU takes a zero-extended immediate
				if (w.i.funct3 == 3'b011)
					dec.imm = {20'b0, w.i.imm};
				else
					dec.imm = {{20{w.i.imm[11]}}, w.i.imm};
			end
			rv_pkg::opc_load: begin
				dec.op_class  = rv_pkg::cls_load;
				dec.src_b_imm = 1'b1;
				dec.imm       = {{20{w.i.imm[11]}}, w.i.imm};
			end
			rv_pkg::opc_store: begin
				dec.op_class  = rv_pkg::cls_store;
				dec.src_b_imm = 1'b1;
				dec.imm       = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
			end
			rv_pkg::opc_branch: begin
				dec.op_class = rv_pkg::cls_branch;
				dec.imm      = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
					w.b.imm_10_5, w.b.imm_4_1, 1'b0};
				// BEQ/BNE on zero flag, others on compare bit
				if (!w.b.funct3[2])
					dec.alu_op = rv_pkg::alu_sub;
				else if (!w.b.funct3[1])
					dec.alu_op = rv_pkg::alu_slt;
				else
					dec.alu_op = rv_pkg::alu_sltu;
			end
			rv_pkg::opc_jal: begin
				dec.op_class  = rv_pkg::cls_jump;
				dec.src_a_pc  = 1'b1;
				dec.src_b_imm = 1'b1;
				dec.link      = 1'b1;
				dec.imm       = {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12,
					w.j.imm_11, w.j.imm_10_1, 1'b0};
			end
			rv_pkg::opc_jalr: begin
				dec.op_class  = rv_pkg::cls_jump;
				dec.src_b_imm = 1'b1;
				dec.is_jalr   = 1'b1;
				dec.link      = 1'b1;
				dec.imm       = {{20{w.i.imm[11]}}, w.i.imm};
			end
			rv_pkg::opc_lui: begin
				dec.op_class = rv_pkg::cls_upper;
				dec.is_lui   = 1'b1;
				dec.imm      = {w.u.imm, 12'b0};
			end
			rv_pkg::opc_auipc: begin
				dec.op_class  = rv_pkg::cls_upper;
				dec.src_a_pc  = 1'b1;
				dec.src_b_imm = 1'b1;
				dec.imm       = {w.u.imm, 12'b0};
			end
			default: begin
				// Unknown opcode, falls through to next fetch
				dec.op_class = rv_pkg::cls_other;
			end
		endcase
	end

endmodule

// File: source/rv_reg_file.sv
`timescale 1ns/1ns

module rv_reg_file (
	input  logic              clk,
	input  rv_pkg::reg_addr_t raddr1,
	input  rv_pkg::reg_addr_t raddr2,
	output rv_pkg::word_t     rdata1,
	output rv_pkg::word_t     rdata2,
	input  logic              wen,
	input  rv_pkg::reg_addr_t waddr,
	input  rv_pkg::word_t     wdata
);

	rv_pkg::word_t regs [32];

	// Write at the edge, x0 never written
	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// Asynchronous reads, x0 forced to zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ns

module rv_execute (
	input  logic            clk,
	input  logic            capture,
	input  logic            latch,
	input  rv_pkg::decode_t dec,
	input  rv_pkg::word_t   rs1_data,
	input  rv_pkg::word_t   rs2_data,
	input  rv_pkg::word_t   fetch_pc,
	input  rv_pkg::word_t   load_word,
	output rv_pkg::word_t   next_pc,
	output rv_pkg::word_t   wb_data,
	output rv_pkg::word_t   address,
	output rv_pkg::word_t   write_data
);

	// Operand and store-data registers
	rv_pkg::word_t a_q;
	rv_pkg::word_t b_q;
	rv_pkg::word_t store_q;
	rv_pkg::word_t result_q;

	rv_pkg::word_t alu_result;
	logic          alu_zero;
	logic          taken;
	rv_pkg::word_t pc_plus4;
	rv_pkg::word_t branch_target;
	rv_pkg::word_t jump_target;

	// Operands sampled in decode
	always_ff @(posedge clk) begin
		if (capture) begin
			a_q     <= dec.src_a_pc ? fetch_pc : rs1_data;
			b_q     <= dec.src_b_imm ? dec.imm : rs2_data;
			store_q <= rs2_data;
		end
	end

	rv_alu rv_alu_i (
		.a      (a_q),
		.b      (b_q),
		.op     (dec.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// Result held from end of execute
	always_ff @(posedge clk) begin
		if (latch)
			result_q <= alu_result;
	end

	// funct3[2] picks compare bit over zero flag
	// funct3[0] inverts the condition
	assign taken = dec.funct3[2] ? (alu_result[0] ^ dec.funct3[0])
		: (alu_zero ^ dec.funct3[0]);

	assign pc_plus4      = fetch_pc + 32'd4;
	assign branch_target = fetch_pc + dec.imm;
	// JALR clears the low bit of the sum
	assign jump_target   = dec.is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

	always_comb begin
		if (dec.op_class == rv_pkg::cls_branch && taken)
			next_pc = branch_target;
		else if (dec.op_class == rv_pkg::cls_jump)
			next_pc = jump_target;
		else
			next_pc = pc_plus4;
	end

	// Word aligned memory address
	assign address    = {result_q[31:2], 2'b00};
	assign write_data = store_q;

	// Write-back source
	always_comb begin
		if (dec.op_class == rv_pkg::cls_load)
			wb_data = load_word;
		else if (dec.link)
			wb_data = pc_plus4;
		else if (dec.is_lui)
			wb_data = dec.imm;
		else
			wb_data = result_q;
	end

endmodule

// File: source/rv_control.sv
`timescale 1ns/1ns

module rv_control #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic            clk,
	input  logic            rst,
	input  rv_pkg::decode_t dec,
	input  rv_pkg::word_t   next_pc,
	output rv_pkg::word_t   pc,
	output logic            inst_req_valid,
	input  logic            inst_req_ready,
	input  rv_pkg::word_t   instruction,
	input  logic            inst_valid,
	output logic            inst_ready,
	output logic            mem_read,
	output logic            mem_write,
	input  logic            mem_req_ready,
	input  rv_pkg::word_t   read_data,
	input  logic            read_data_valid,
	output logic            read_data_ready,
	output rv_pkg::word_t   fetch_pc,
	output rv_pkg::word_t   instr_word,
	output rv_pkg::word_t   load_word,
	output logic            capture,
	output logic            latch,
	output logic            reg_write
);

	// One-hot state bit positions
	localparam int st_reset      = 0;
	localparam int st_fetch      = 1;
	localparam int st_fetch_wait = 2;
	localparam int st_decode     = 3;
	localparam int st_execute    = 4;
	localparam int st_load       = 5;
	localparam int st_store      = 6;
	localparam int st_read_wait  = 7;
	localparam int st_write_back = 8;

	logic [8:0] state_q;
	logic [8:0] state_d;

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= 9'b1 << st_reset;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = '0;
		case (1'b1)
			state_q[st_reset]: state_d[st_fetch] = 1'b1;
			// Hold fetch until request accepted
			state_q[st_fetch]: state_d[inst_req_ready ? st_fetch_wait : st_fetch] = 1'b1;
			state_q[st_fetch_wait]: state_d[inst_valid ? st_decode : st_fetch_wait] = 1'b1;
			state_q[st_decode]: state_d[st_execute] = 1'b1;
			state_q[st_execute]: begin
				case (dec.op_class)
					rv_pkg::cls_load:  state_d[st_load] = 1'b1;
					rv_pkg::cls_store: state_d[st_store] = 1'b1;
					rv_pkg::cls_alu, rv_pkg::cls_upper, rv_pkg::cls_jump:
						state_d[st_write_back] = 1'b1;
					// Branches and unknown opcodes refetch
					default: state_d[st_fetch] = 1'b1;
				endcase
			end
			state_q[st_load]: state_d[mem_req_ready ? st_read_wait : st_load] = 1'b1;
			state_q[st_store]: state_d[mem_req_ready ? st_fetch : st_store] = 1'b1;
			state_q[st_read_wait]: state_d[read_data_valid ? st_write_back : st_read_wait] = 1'b1;
			state_q[st_write_back]: state_d[st_fetch] = 1'b1;
			default: state_d[st_reset] = 1'b1;
		endcase
	end

	// PC moves only at the end of execute
	always_ff @(posedge clk) begin
		if (rst)
			pc <= reset_pc;
		else if (state_q[st_execute])
			pc <= next_pc;
	end

	// Payload registers, loaded on their handshakes
	always_ff @(posedge clk) begin
		if (state_q[st_fetch])
			fetch_pc <= pc;
		if (inst_ready && inst_valid)
			instr_word <= instruction;
		if (read_data_ready && read_data_valid)
			load_word <= read_data;
	end

	// Channel strobes, ready also high in reset state
	assign inst_req_valid  = state_q[st_fetch];
	assign inst_ready      = state_q[st_reset] | state_q[st_fetch_wait];
	assign read_data_ready = state_q[st_reset] | state_q[st_read_wait];
	assign mem_read        = state_q[st_load];
	assign mem_write       = state_q[st_store];

	// Datapath pulses
	assign capture   = state_q[st_decode];
	assign latch     = state_q[st_execute];
	assign reg_write = state_q[st_write_back];

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ns

module rv_core #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  logic          clk,
	input  logic          rst,
	// Instruction request
	output rv_pkg::word_t pc,
	output logic          inst_req_valid,
	input  logic          inst_req_ready,
	// Instruction response
	input  rv_pkg::word_t instruction,
	input  logic          inst_valid,
	output logic          inst_ready,
	// Memory request
	output rv_pkg::word_t address,
	output logic          mem_write,
	output rv_pkg::word_t write_data,
	output logic          mem_read,
	input  logic          mem_req_ready,
	// Read response
	input  rv_pkg::word_t read_data,
	input  logic          read_data_valid,
	output logic          read_data_ready
);

	rv_pkg::decode_t dec;
	rv_pkg::word_t   next_pc;
	rv_pkg::word_t   fetch_pc;
	rv_pkg::word_t   instr_word;
	rv_pkg::word_t   load_word;
	rv_pkg::word_t   rs1_data;
	rv_pkg::word_t   rs2_data;
	rv_pkg::word_t   wb_data;
	logic            capture;
	logic            latch;
	logic            reg_write;

	// FSM, PC and handshakes
	rv_control #(
		.reset_pc (reset_pc)
	) rv_control_i (
		.clk             (clk),
		.rst             (rst),
		.dec             (dec),
		.next_pc         (next_pc),
		.pc              (pc),
		.inst_req_valid  (inst_req_valid),
		.inst_req_ready  (inst_req_ready),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_req_ready   (mem_req_ready),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ready (read_data_ready),
		.fetch_pc        (fetch_pc),
		.instr_word      (instr_word),
		.load_word       (load_word),
		.capture         (capture),
		.latch           (latch),
		.reg_write       (reg_write)
	);

	rv_decode rv_decode_i (
		.instr_word (instr_word),
		.dec        (dec)
	);

	// Read addresses straight from the decoder
	rv_reg_file rv_reg_file_i (
		.clk    (clk),
		.raddr1 (dec.rs1),
		.raddr2 (dec.rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data),
		.wen    (reg_write),
		.waddr  (dec.rd),
		.wdata  (wb_data)
	);

	rv_execute rv_execute_i (
		.clk        (clk),
		.capture    (capture),
		.latch      (latch),
		.dec        (dec),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.fetch_pc   (fetch_pc),
		.load_word  (load_word),
		.next_pc    (next_pc),
		.wb_data    (wb_data),
		.address    (address),
		.write_data (write_data)
	);

endmodule

// File: dv/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;

	localparam rv_pkg::word_t reset_pc = 32'h100;

	logic clk;
	logic rst;
	rv_pkg::word_t pc;
	logic inst_req_valid;
	logic inst_req_ready;
	rv_pkg::word_t instruction;
	logic inst_valid;
	logic inst_ready;
	rv_pkg::word_t address;
	logic mem_write;
	rv_pkg::word_t write_data;
	logic mem_read;
	logic mem_req_ready;
	rv_pkg::word_t read_data;
	logic read_data_valid;
	logic read_data_ready;

	// Program, data and the expected store sequence
	rv_pkg::word_t imem [256];
	rv_pkg::word_t dmem [1024];
	rv_pkg::word_t exp_addr [128];
	rv_pkg::word_t exp_data [128];
	rv_pkg::word_t xr [32];
	logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	int n_ins = 0;
	int n_exp = 0;
	int store_cnt = 0;
	logic [11:0] slot = 12'h400;

	// Handshake bookkeeping updated at the rising edge
	logic rst_q = 1'b0;
	logic first_fetch = 1'b1;
	logic ifetch_pend = 1'b0;
	logic rd_pend = 1'b0;
	rv_pkg::word_t rd_addr = '0;
	logic held_req = 1'b0;
	logic held_mem = 1'b0;
	logic prev_rd;
	logic prev_wr;
	rv_pkg::word_t prev_pc;
	rv_pkg::word_t prev_addr;
	rv_pkg::word_t prev_wdata;

	// Stall counters per channel
	logic req_busy = 1'b0;
	logic resp_busy = 1'b0;
	logic mem_busy = 1'b0;
	logic rd_busy = 1'b0;
	logic [1:0] req_cnt;
	logic [1:0] resp_cnt;
	logic [1:0] mem_cnt;
	logic [1:0] rd_cnt;
	logic [15:0] lfsr = 16'd26;
	logic [7:0] iidx;
	logic [6:0] sidx;

	assign iidx = 8'((pc - reset_pc) >> 2);
	assign sidx = 7'(store_cnt);

	rv_core #(
		.reset_pc (reset_pc)
	) rv_core_i (
		.clk             (clk),
		.rst             (rst),
		.pc              (pc),
		.inst_req_valid  (inst_req_valid),
		.inst_req_ready  (inst_req_ready),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.address         (address),
		.mem_write       (mem_write),
		.write_data      (write_data),
		.mem_read        (mem_read),
		.mem_req_ready   (mem_req_ready),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ready (read_data_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [1:0] stall_len();
		logic hi;
		logic lo;
		hi = lfsr_bit();
		lo = lfsr_bit();
		return {hi, lo};
	endfunction

	task automatic value_mismatch(input string name, input rv_pkg::word_t exp,
		input rv_pkg::word_t got);
		$display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
		$display("SIMULATION FAILED");
		$fatal(1, "wrong value on %s", name);
	endtask

	task automatic abort_run(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1, "%s", msg);
	endtask

	// Hold one ready or valid low for 0 to 3 cycles
	task automatic pace(input logic active, inout logic busy, inout logic [1:0] cnt,
		output logic go);
		if (!active) begin
			busy = 1'b0;
			go = 1'b0;
		end else begin
			if (!busy) begin
				busy = 1'b1;
				cnt = stall_len();
			end
			go = (cnt == 2'd0);
			if (cnt != 2'd0)
				cnt = cnt - 2'd1;
		end
	endtask

	// All inputs change on the falling edge
	always @(negedge clk) begin
		pace(inst_req_valid, req_busy, req_cnt, inst_req_ready);
		pace(ifetch_pend && inst_ready, resp_busy, resp_cnt, inst_valid);
		pace(mem_read || mem_write, mem_busy, mem_cnt, mem_req_ready);
		pace(rd_pend && read_data_ready, rd_busy, rd_cnt, read_data_valid);
		instruction = imem[iidx];
		read_data = dmem[rd_addr[11:2]];
	end

	// Memory side of the handshakes
	always @(posedge clk) begin
		rst_q <= rst;
		if (inst_req_valid && inst_req_ready) begin
			ifetch_pend <= 1'b1;
			first_fetch <= 1'b0;
		end
		if (inst_valid && inst_ready)
			ifetch_pend <= 1'b0;
		if (mem_read && mem_req_ready) begin
			rd_pend <= 1'b1;
			rd_addr <= address;
		end
		if (read_data_valid && read_data_ready)
			rd_pend <= 1'b0;
		if (mem_write && mem_req_ready) begin
			dmem[address[11:2]] <= write_data;
			store_cnt <= store_cnt + 1;
		end
		held_req <= inst_req_valid && !inst_req_ready;
		held_mem <= (mem_read || mem_write) && !mem_req_ready;
		prev_rd <= mem_read;
		prev_wr <= mem_write;
		prev_pc <= pc;
		prev_addr <= address;
		prev_wdata <= write_data;
	end

	a_reset_quiet: assert property (@(posedge clk)
		rst_q |-> !inst_req_valid && !mem_read && !mem_write)
		else abort_run("request strobe high during or right after reset");
	a_first_pc: assert property (@(posedge clk) disable iff (rst)
		first_fetch && inst_req_valid |-> pc == reset_pc)
		else value_mismatch("pc", reset_pc, $sampled(pc));
	// Ready high in the reset state and while a response is owed
	a_inst_ready: assert property (@(posedge clk) disable iff (rst)
		inst_ready == (ifetch_pend || rst_q))
		else value_mismatch("inst_ready", $sampled(ifetch_pend || rst_q),
			$sampled(inst_ready));
	a_rd_ready: assert property (@(posedge clk) disable iff (rst)
		read_data_ready == (rd_pend || rst_q))
		else value_mismatch("read_data_ready", $sampled(rd_pend || rst_q),
			$sampled(read_data_ready));
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		held_req |-> inst_req_valid)
		else abort_run("inst_req_valid dropped before inst_req_ready");
	a_pc_hold: assert property (@(posedge clk) disable iff (rst)
		held_req |-> pc == prev_pc)
		else value_mismatch("pc", $sampled(prev_pc), $sampled(pc));
	a_mem_hold: assert property (@(posedge clk) disable iff (rst)
		held_mem |-> mem_read == prev_rd && mem_write == prev_wr)
		else abort_run("memory request dropped before mem_req_ready");
	a_addr_hold: assert property (@(posedge clk) disable iff (rst)
		held_mem |-> address == prev_addr)
		else value_mismatch("address", $sampled(prev_addr), $sampled(address));
	a_wdata_hold: assert property (@(posedge clk) disable iff (rst)
		held_mem && prev_wr |-> write_data == prev_wdata)
		else value_mismatch("write_data", $sampled(prev_wdata), $sampled(write_data));
	a_store_count: assert property (@(posedge clk) disable iff (rst)
		mem_write && mem_req_ready |-> store_cnt < n_exp)
		else abort_run("store beyond the expected sequence");
	a_store_addr: assert property (@(posedge clk) disable iff (rst)
		mem_write && mem_req_ready && store_cnt < n_exp |-> address == exp_addr[sidx])
		else value_mismatch("address", exp_addr[$sampled(sidx)], $sampled(address));
	a_store_data: assert property (@(posedge clk) disable iff (rst)
		mem_write && mem_req_ready && store_cnt < n_exp |-> write_data == exp_data[sidx])
		else value_mismatch("write_data", exp_data[$sampled(sidx)], $sampled(write_data));

	// Instruction encoders
	function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	// SW with x0 as base
	function automatic rv_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv_pkg::word_t enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rv_pkg::word_t enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// Reference results from the RV32I rules
	function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
		input rv_pkg::word_t a, input rv_pkg::word_t b);
		rv_pkg::word_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'b0, $signed(a) < $signed(b)};
			3'd3: r = {31'b0, a < b};
			3'd4: r = a ^ b;
			3'd6: r = a | b;
			3'd7: r = a & b;
			default: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
		endcase
		return r;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
		input rv_pkg::word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(input rv_pkg::word_t w);
		imem[8'(n_ins)] = w;
		n_ins++;
	endtask

	function automatic rv_pkg::word_t here();
		return reset_pc + 32'(n_ins) * 32'd4;
	endfunction

	task automatic set_reg(input logic [4:0] rd, input rv_pkg::word_t v);
		if (rd != 5'd0)
			xr[rd] = v;
	endtask

	task automatic expect_store(input logic [11:0] addr, input rv_pkg::word_t v);
		exp_addr[7'(n_exp)] = {20'b0, addr};
		exp_data[7'(n_exp)] = v;
		n_exp++;
	endtask

	// Report a register at the next free slot
	task automatic store_reg(input logic [4:0] rs);
		emit(enc_s(slot, rs));
		expect_store(slot, xr[rs]);
		slot = slot + 12'd4;
	endtask

	// LUI plus ADDI
	task automatic load_const(input logic [4:0] rd, input rv_pkg::word_t v);
		rv_pkg::word_t upper;
		upper = (v + 32'h800) >> 12;
		emit({upper[19:0], rd, 7'b0110111});
		emit(enc_i(v[11:0], rd, 3'd0, rd, 7'b0010011));
		set_reg(rd, v);
	endtask

	task automatic op_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
		set_reg(rd, alu_ref(f3, alt, xr[rs1], xr[rs2]));
		store_reg(rd);
	endtask

	task automatic op_i(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		logic [11:0] fld;
		rv_pkg::word_t bv;
		fld = (f3 == 3'd1 || f3 == 3'd5) ? {alt ? 7'h20 : 7'h00, imm[4:0]} : imm;
		// SLTIU takes a zero-extended immediate
		bv = (f3 == 3'd3) ? {20'b0, imm} : {{20{imm[11]}}, imm};
		emit(enc_i(fld, rs1, f3, rd, 7'b0010011));
		set_reg(rd, alu_ref(f3, alt, xr[rs1], bv));
		store_reg(rd);
	endtask

	// A taken branch skips one store and leaves a gap in the address sequence
	task automatic branch_case(input logic [2:0] f3, input logic [4:0] ra,
		input logic [4:0] rb);
		logic [11:0] skip_slot;
		emit(enc_b(13'd8, rb, ra, f3));
		skip_slot = slot;
		slot = slot + 12'd4;
		emit(enc_s(skip_slot, 5'd2));
		if (!branch_taken(f3, xr[ra], xr[rb]))
			expect_store(skip_slot, xr[2]);
		store_reg(5'd2);
	endtask

	initial begin
		rst = 1'b1;
		inst_req_ready = 1'b0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		read_data_valid = 1'b0;
		instruction = '0;
		read_data = '0;
		xr[0] = '0;

		load_const(5'd1, 32'hFFFF_FFFB);
		load_const(5'd2, 32'd7);
		load_const(5'd11, 32'h8765_4321);
		load_const(5'd12, 32'd19);
		load_const(5'd13, -32'sd100);
		// Register forms
		for (int f = 0; f < 8; f++)
			op_r(3'(f), 1'b0, 5'd14, 5'd11, 5'd12);
		op_r(3'd0, 1'b1, 5'd14, 5'd11, 5'd12);
		op_r(3'd5, 1'b1, 5'd14, 5'd11, 5'd12);
		op_r(3'd2, 1'b0, 5'd15, 5'd13, 5'd12);
		op_r(3'd3, 1'b0, 5'd15, 5'd13, 5'd12);
		// x0 ignores the write
		op_r(3'd0, 1'b0, 5'd0, 5'd11, 5'd12);
		// Immediate forms
		for (int f = 0; f < 8; f++)
			op_i(3'(f), 1'b0, 5'd16, 5'd11, 12'h0A5);
		op_i(3'd5, 1'b1, 5'd16, 5'd11, 12'd5);
		op_i(3'd2, 1'b0, 5'd16, 5'd13, 12'hF00);
		op_i(3'd0, 1'b0, 5'd16, 5'd13, 12'h800);
		// LUI and AUIPC
		emit({20'hABCDE, 5'd17, 7'b0110111});
		set_reg(5'd17, 32'hABCD_E000);
		store_reg(5'd17);
		set_reg(5'd18, here() + 32'h1234_5000);
		emit({20'h12345, 5'd18, 7'b0010111});
		store_reg(5'd18);
		// JAL over one store
		set_reg(5'd19, here() + 32'd4);
		emit(enc_j(21'd8, 5'd19));
		emit(enc_s(12'h7FC, 5'd0));
		store_reg(5'd19);
		// JALR with an odd sum drops the low bit
		load_const(5'd20, here() + 32'd16);
		set_reg(5'd21, here() + 32'd4);
		emit(enc_i(12'd1, 5'd20, 3'd0, 5'd21, 7'b1100111));
		emit(enc_s(12'h7FC, 5'd0));
		store_reg(5'd21);
		// Store, load back, modify, store again
		emit(enc_s(12'h200, 5'd11));
		expect_store(12'h200, xr[11]);
		emit(enc_i(12'h200, 5'd0, 3'b010, 5'd22, 7'b0000011));
		set_reg(5'd22, xr[11]);
		op_i(3'd0, 1'b0, 5'd22, 5'd22, 12'd13);
		// Each branch both ways
		for (int k = 0; k < 6; k++) begin
			branch_case(br_f3[k], 5'd1, 5'd2);
			branch_case(br_f3[k], 5'd2, 5'd1);
			branch_case(br_f3[k], 5'd1, 5'd1);
		end
		// Park on a jump to itself
		emit(enc_j(21'd0, 5'd0));

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (store_cnt < n_exp)
			@(posedge clk);
		// Let the core idle on its self jump
		repeat (40) @(posedge clk);
		$display("SIMULATION PASSED");
		$finish;
	end

	// Watchdog scaled from program length
	initial begin
		#1;
		#(n_ins * 6 * 4 * 40 * 4);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired before the program finished");
	end

endmodule

// File: files.f
source/rv_pkg.sv
source/rv_alu.sv
source/rv_decode.sv
source/rv_reg_file.sv
source/rv_execute.sv
source/rv_control.sv
source/rv_core.sv
dv/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f files.f --top-module rv_core_tb -o rv_core_sim \
	&& ./obj_dir/rv_core_sim \
	|| exit 1
